//--- Makefile
# Verilator build and run for the simulation harness testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := tb_sim_harness_top
FILELIST  := sim_harness_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim_harness_top.f
+incdir+src
src/sim_pkg.sv
src/bus_latency_responder.sv
src/instr_mix_classifier.sv
src/mix_stats_counters.sv
src/sim_harness_top.sv
verif/tb_sim_harness_top.sv

//--- src/bus_latency_responder.sv
//////////////////////////////////////////////////////////////////////
// one read and one write outstanding at a time
// reads return a constant word, write data is dropped
// console byte is wdata[7:0] regardless of wstrb
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sim_macros.svh"

module bus_latency_responder (
    input  logic             clk,
    input  logic             rst,
    input  sim_pkg::bus_req_t req,
    output sim_pkg::bus_rsp_t rsp,
    output logic             console_valid,
    output logic [7:0]       console_byte
);
    import sim_pkg::*;

    localparam int rd_cnt_w = $clog2(`MEM_READ_LATENCY + 1);
    localparam int wr_cnt_w = $clog2(`MEM_WRITE_LATENCY + 1);

    logic                arready_q;
    logic                rd_busy;
    logic [rd_cnt_w-1:0] rd_cnt;
    logic                rvalid_q;

    logic                awready_q;
    logic                wr_busy;
    logic [wr_cnt_w-1:0] wr_cnt;
    logic                wready_q;
    logic                b_pend;
    logic                bvalid_q;
    logic [13:0]         aw_addr_q;

    logic ar_xfer;
    logic r_xfer;
    logic aw_xfer;
    logic w_xfer;
    logic b_xfer;

    assign ar_xfer = req.arvalid && arready_q;
    assign r_xfer  = rvalid_q && req.rready;
    assign aw_xfer = req.awvalid && awready_q;
    assign w_xfer  = req.wvalid && wready_q;
    assign b_xfer  = bvalid_q && req.bready;

    //////////////////////////////////////////////////////////////////////
    // read channel
    always_ff @(posedge clk) begin
        if (rst) begin
            arready_q <= 1'b1;
            rd_busy   <= 1'b0;
            rd_cnt    <= '0;
            rvalid_q  <= 1'b0;
        end else begin
            if (ar_xfer) begin
                arready_q <= 1'b0;
                rd_busy   <= 1'b1;
                rd_cnt    <= rd_cnt_w'(`MEM_READ_LATENCY - 1);
            end else if (rd_busy) begin
                if (rd_cnt == '0) begin
                    rd_busy  <= 1'b0;
                    rvalid_q <= 1'b1;
                end else begin
                    rd_cnt <= rd_cnt - 1'b1;
                end
            end

            // address side reopens with the data handshake
            if (r_xfer) begin
                rvalid_q  <= 1'b0;
                arready_q <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write channels
    always_ff @(posedge clk) begin
        if (rst) begin
            awready_q <= 1'b1;
            wr_busy   <= 1'b0;
            wr_cnt    <= '0;
            wready_q  <= 1'b0;
            b_pend    <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            if (aw_xfer) begin
                awready_q <= 1'b0;
                wr_busy   <= 1'b1;
                wr_cnt    <= wr_cnt_w'(`MEM_WRITE_LATENCY - 1);
            end else if (wr_busy) begin
                if (wr_cnt == '0) begin
                    wr_busy  <= 1'b0;
                    wready_q <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt - 1'b1;
                end
            end

            // response goes out one edge after the data beat
            b_pend <= w_xfer;
            if (w_xfer) begin
                wready_q <= 1'b0;
            end
            if (b_pend) begin
                bvalid_q <= 1'b1;
            end else if (b_xfer) begin
                bvalid_q  <= 1'b0;
                awready_q <= 1'b1;
            end
        end
    end

    // only the console offset bits are kept
    always_ff @(posedge clk) begin
        if (aw_xfer) begin
            aw_addr_q <= req.awaddr[13:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // console capture
    always_ff @(posedge clk) begin
        if (rst) begin
            console_valid <= 1'b0;
        end else begin
            console_valid <= w_xfer && (aw_addr_q == `CONSOLE_ADDR);
        end
    end

    always_ff @(posedge clk) begin
        if (w_xfer) begin
            console_byte <= req.wdata[7:0];
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.arready = arready_q;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = `MEM_READ_DATA;
        rsp.rresp   = 2'b00;
        rsp.awready = awready_q;
        rsp.wready  = wready_q;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = 2'b00;
    end

    // responses may not be withdrawn before the manager takes them
    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rsp.rvalid && !req.rready |=> rsp.rvalid);

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rsp.bvalid && !req.bready |=> rsp.bvalid);

endmodule

`default_nettype wire

//--- src/instr_mix_classifier.sv
//////////////////////////////////////////////////////////////////////
// one register stage, outputs lag the retire group by one edge
// mul/div detection assumes the M extension encoding on arith ops
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sim_macros.svh"

module instr_mix_classifier (
    input  logic                  clk,
    input  logic                  rst,
    input  sim_pkg::retire_port_t retire [`RETIRE_PORTS],
    output sim_pkg::mix_class_t   port_class [`RETIRE_PORTS],
    output logic                  start_hit,
    output logic                  end_hit
);
    import sim_pkg::*;

    opcode_e    op [`RETIRE_PORTS];
    logic       is_mext [`RETIRE_PORTS];
    mix_class_t class_d [`RETIRE_PORTS];
    logic       start_d;
    logic       end_d;

    //////////////////////////////////////////////////////////////////////
    // per-port decode
    always_comb begin
        start_d = 1'b0;
        end_d   = 1'b0;
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            op[i]      = opcode_e'(retire[i].instr.r.opcode[6:2]);
            // funct7 bit 0 marks multiply/divide on register ops
            is_mext[i] = (op[i] == arith) && retire[i].instr.r.funct7[0];

            class_d[i].alu   = retire[i].valid && !is_mext[i]
                               && (op[i] inside {arith, arith_imm, auipc, lui});
            class_d[i].br    = retire[i].valid && (op[i] inside {branch, jal, jalr});
            class_d[i].mul   = retire[i].valid && is_mext[i] && !retire[i].instr.r.funct3[2];
            class_d[i].div   = retire[i].valid && is_mext[i] && retire[i].instr.r.funct3[2];
            // amo counts as both a load and a store
            class_d[i].load  = retire[i].valid && (op[i] inside {load, amo});
            class_d[i].store = retire[i].valid && (op[i] inside {store, amo});
            class_d[i].misc  = retire[i].valid && (op[i] inside {system, fence});

            start_d |= retire[i].valid && (retire[i].instr.raw == `START_MARKER);
            end_d   |= retire[i].valid && (retire[i].instr.raw == `END_MARKER);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            start_hit <= 1'b0;
            end_hit   <= 1'b0;
            for (int i = 0; i < `RETIRE_PORTS; i++) begin
                port_class[i] <= '0;
            end
        end else begin
            start_hit <= start_d;
            end_hit   <= end_d;
            for (int i = 0; i < `RETIRE_PORTS; i++) begin
                port_class[i] <= class_d[i];
            end
        end
    end

    // at most one execution class per word, mul and div included
    for (genvar g = 0; g < `RETIRE_PORTS; g++) begin : gen_chk
        class_excl: assert property (@(posedge clk) disable iff (rst)
            $onehot0({port_class[g].alu, port_class[g].br, port_class[g].mul,
                      port_class[g].div, port_class[g].misc}));
    end

endmodule

`default_nettype wire

//--- src/mix_stats_counters.sv
//////////////////////////////////////////////////////////////////////
// counters wrap silently at COUNT_W bits
// end marker wins over start marker in the same group
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sim_macros.svh"

module mix_stats_counters (
    input  logic                 clk,
    input  logic                 rst,
    input  sim_pkg::mix_class_t  port_class [`RETIRE_PORTS],
    input  logic                 start_hit,
    input  logic                 end_hit,
    output sim_pkg::mix_counts_t counts,
    output logic                 window_active,
    output logic                 stats_done
);
    import sim_pkg::*;

    localparam int num_class = $bits(mix_class_t);
    localparam int pop_w     = $clog2(`RETIRE_PORTS + 1);

    // index c+1 holds class bit c, index 0 is the cycle count
    logic [num_class:0][`COUNT_W-1:0] cnt_q;
    logic [num_class-1:0][pop_w-1:0]  pop;
    logic                             counting;

    //////////////////////////////////////////////////////////////////////
    // per-class population across the ports
    always_comb begin
        pop = '0;
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            for (int c = 0; c < num_class; c++) begin
                pop[c] = pop[c] + pop_w'(port_class[i][c]);
            end
        end
    end

    // marker cycles never count
    assign counting = window_active && !start_hit && !end_hit;

    //////////////////////////////////////////////////////////////////////
    // window control
    always_ff @(posedge clk) begin
        if (rst) begin
            window_active <= 1'b0;
            stats_done    <= 1'b0;
        end else begin
            stats_done <= end_hit && window_active;
            if (end_hit) begin
                window_active <= 1'b0;
            end else if (start_hit) begin
                window_active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start_hit) begin
            cnt_q <= '0;
        end else if (counting) begin
            cnt_q[0] <= cnt_q[0] + 1'b1;
            for (int c = 0; c < num_class; c++) begin
                cnt_q[c+1] <= cnt_q[c+1] + `COUNT_W'(pop[c]);
            end
        end
    end

    assign counts = cnt_q;

    // the closed window cannot end a second time
    done_single_pulse: assert property (@(posedge clk) disable iff (rst)
        stats_done |=> !stats_done);

endmodule

`default_nettype wire

//--- src/sim_harness_top.sv
//////////////////////////////////////////////////////////////////////
// retire ports are driven from outside, no core inside
// counts are valid while stats_done is high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sim_macros.svh"

module sim_harness_top (
    input  logic                  clk,
    input  logic                  rst,
    input  sim_pkg::bus_req_t     req,
    output sim_pkg::bus_rsp_t     rsp,
    output logic                  console_valid,
    output logic [7:0]            console_byte,
    input  sim_pkg::retire_port_t retire [`RETIRE_PORTS],
    output sim_pkg::mix_counts_t  counts,
    output logic                  window_active,
    output logic                  stats_done
);
    import sim_pkg::*;

    mix_class_t port_class [`RETIRE_PORTS];
    logic       start_hit;
    logic       end_hit;

    //////////////////////////////////////////////////////////////////////
    // memory bus and console
    bus_latency_responder u_bus_latency_responder (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .rsp           (rsp),
        .console_valid (console_valid),
        .console_byte  (console_byte)
    );

    //////////////////////////////////////////////////////////////////////
    // instruction mix, classify then count
    instr_mix_classifier u_instr_mix_classifier (
        .clk        (clk),
        .rst        (rst),
        .retire     (retire),
        .port_class (port_class),
        .start_hit  (start_hit),
        .end_hit    (end_hit)
    );

    mix_stats_counters u_mix_stats_counters (
        .clk           (clk),
        .rst           (rst),
        .port_class    (port_class),
        .start_hit     (start_hit),
        .end_hit       (end_hit),
        .counts        (counts),
        .window_active (window_active),
        .stats_done    (stats_done)
    );

endmodule

`default_nettype wire

//--- src/sim_macros.svh
//////////////////////////////////////////////////////////////////////
// latencies are in clock edges and must be at least 1
// console offset is matched on address bits 13:0 only
//////////////////////////////////////////////////////////////////////
`ifndef SIM_MACROS_SVH
`define SIM_MACROS_SVH

// memory bus responder
`define MEM_READ_LATENCY 6
`define MEM_WRITE_LATENCY 6
`define MEM_READ_DATA 32'hFFFFFF21
`define CONSOLE_ADDR 14'h1000

// collection window markers, both are addi x0 forms
`define START_MARKER 32'h00C00013
`define END_MARKER 32'h00D00013

// retire path
`define RETIRE_PORTS 2
`define COUNT_W 32

`endif

//--- src/sim_pkg.sv
//////////////////////////////////////////////////////////////////////
// bus structs carry no IDs and no burst fields
// counter width comes from COUNT_W in the macros header
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "sim_macros.svh"

package sim_pkg;

    //////////////////////////////////////////////////////////////////////
    // memory bus
    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
    } bus_req_t;

    typedef struct packed {
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
    } bus_rsp_t;

    //////////////////////////////////////////////////////////////////////
    // instruction views
    typedef enum logic [4:0] {
        arith     = 5'b01100,
        arith_imm = 5'b00100,
        auipc     = 5'b00101,
        lui       = 5'b01101,
        branch    = 5'b11000,
        jal       = 5'b11011,
        jalr      = 5'b11001,
        load      = 5'b00000,
        amo       = 5'b01011,
        store     = 5'b01000,
        system    = 5'b11100,
        fence     = 5'b00011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // raw view for marker match, R-type view for the class decode
    typedef union packed {
        logic [31:0] raw;
        r_type_t     r;
    } instr_word_u;

    typedef struct packed {
        logic        valid;
        instr_word_u instr;
    } retire_port_t;

    //////////////////////////////////////////////////////////////////////
    // statistics
    typedef struct packed {
        logic alu;
        logic br;
        logic mul;
        logic div;
        logic load;
        logic store;
        logic misc;
    } mix_class_t;

    // field order matches mix_class_t, cycles last
    typedef struct packed {
        logic [`COUNT_W-1:0] alu;
        logic [`COUNT_W-1:0] br;
        logic [`COUNT_W-1:0] mul;
        logic [`COUNT_W-1:0] div;
        logic [`COUNT_W-1:0] load;
        logic [`COUNT_W-1:0] store;
        logic [`COUNT_W-1:0] misc;
        logic [`COUNT_W-1:0] cycles;
    } mix_counts_t;

endpackage

`default_nettype wire

//--- verif/tb_sim_harness_top.sv
//////////////////////////////////////////////////////////////////////
// inputs change on falling edges, outputs are sampled there too
// bus latencies and marker words come from the macros header
// stall lengths and filler words use a fixed seed
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sim_macros.svh"

module tb_sim_harness_top;
    import sim_pkg::*;

    localparam int clk_period  = 20;
    localparam int rst_cycles  = 10;
    localparam int num_steps   = 35;
    localparam int wait_limit  = 20;
    localparam int seed        = 98886;
    localparam int watchdog_ns = (num_steps * 40 + rst_cycles + 4) * clk_period;

    // class masks, bit 6 alu down to bit 0 misc
    localparam logic [6:0] m_alu  = 7'b1000000;
    localparam logic [6:0] m_br   = 7'b0100000;
    localparam logic [6:0] m_mul  = 7'b0010000;
    localparam logic [6:0] m_div  = 7'b0001000;
    localparam logic [6:0] m_ld   = 7'b0000100;
    localparam logic [6:0] m_st   = 7'b0000010;
    localparam logic [6:0] m_misc = 7'b0000001;
    localparam logic [6:0] m_amo  = m_ld | m_st;

    // filler words for random groups and their classes
    localparam logic [31:0] fill_word [8] = '{32'h003100B3, 32'h00108093, 32'h123452B7,
        32'h00208463, 32'h023100B3, 32'h0000A083, 32'h0010A023, 32'h0FF0000F};
    localparam logic [6:0] fill_mask [8] = '{m_alu, m_alu, m_alu, m_br, m_mul, m_ld, m_st,
        m_misc};

    typedef enum logic [1:0] {op_read, op_write, op_retire, op_fill} op_e;

    // a is the address or port 0 word, d the write data or port 1 word
    typedef struct packed {
        op_e         op;
        logic [1:0]  vld;
        logic [31:0] a;
        logic [31:0] d;
        logic [6:0]  m0;
        logic [6:0]  m1;
        logic        con;
    } step_t;

    logic         clk = 1'b0;
    logic         rst;
    bus_req_t     req;
    bus_rsp_t     rsp;
    logic         console_valid;
    logic [7:0]   console_byte;
    retire_port_t retire [`RETIRE_PORTS];
    mix_counts_t  counts;
    logic         window_active;
    logic         stats_done;

    step_t steps [num_steps];
    int    errors = 0;
    int    cyc = 0;
    int    start_cyc = 0;
    int    exp_cnt [8];
    logic  in_window = 1'b0;

    sim_harness_top u_sim_harness_top (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .rsp           (rsp),
        .console_valid (console_valid),
        .console_byte  (console_byte),
        .retire        (retire),
        .counts        (counts),
        .window_active (window_active),
        .stats_done    (stats_done)
    );

    always #(clk_period / 2) clk = ~clk;

    // rising edges so far, read on falling edges only
    always @(posedge clk) cyc <= cyc + 1;

    //////////////////////////////////////////////////////////////////////
    // reporting
    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errors++;
        $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
    endtask

    task automatic plain_error(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic compare_counts();
        if (counts.alu !== exp_cnt[0]) value_mismatch("counts.alu", counts.alu, exp_cnt[0]);
        if (counts.br !== exp_cnt[1]) value_mismatch("counts.br", counts.br, exp_cnt[1]);
        if (counts.mul !== exp_cnt[2]) value_mismatch("counts.mul", counts.mul, exp_cnt[2]);
        if (counts.div !== exp_cnt[3]) value_mismatch("counts.div", counts.div, exp_cnt[3]);
        if (counts.load !== exp_cnt[4]) value_mismatch("counts.load", counts.load, exp_cnt[4]);
        if (counts.store !== exp_cnt[5]) value_mismatch("counts.store", counts.store, exp_cnt[5]);
        if (counts.misc !== exp_cnt[6]) value_mismatch("counts.misc", counts.misc, exp_cnt[6]);
        if (counts.cycles !== exp_cnt[7]) value_mismatch("counts.cycles", counts.cycles, exp_cnt[7]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus manager
    task automatic read_word(input logic [31:0] addr);
        int edges;
        int stall;
        edges = 0;
        stall = $urandom_range(3, 0);
        if (rsp.arready !== 1'b1) plain_error("arready low while the read channel is idle");
        req.arvalid = 1'b1;
        req.araddr  = addr;
        @(negedge clk);
        req.arvalid = 1'b0;
        while (rsp.rvalid !== 1'b1 && edges < wait_limit) begin
            if (rsp.arready !== 1'b0) value_mismatch("arready", rsp.arready, 0);
            @(negedge clk);
            edges++;
        end
        if (rsp.rvalid !== 1'b1) begin
            plain_error("rvalid never rose after a read address");
            return;
        end
        if (edges != `MEM_READ_LATENCY) value_mismatch("read latency", edges, `MEM_READ_LATENCY);
        for (int k = 0; k <= stall; k++) begin
            if (k > 0) @(negedge clk);
            if (rsp.rvalid !== 1'b1) value_mismatch("rvalid", rsp.rvalid, 1);
            if (rsp.rdata !== 32'hFFFFFF21) value_mismatch("rdata", rsp.rdata, 32'hFFFFFF21);
            if (rsp.rresp !== 2'b00) value_mismatch("rresp", rsp.rresp, 0);
            if (rsp.arready !== 1'b0) value_mismatch("arready", rsp.arready, 0);
        end
        req.rready = 1'b1;
        @(negedge clk);
        req.rready = 1'b0;
        if (rsp.rvalid !== 1'b0) value_mismatch("rvalid", rsp.rvalid, 0);
        if (rsp.arready !== 1'b1) value_mismatch("arready", rsp.arready, 1);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data, input logic con);
        int edges;
        int stall;
        edges = 0;
        stall = $urandom_range(3, 0);
        if (rsp.awready !== 1'b1) plain_error("awready low while the write channel is idle");
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        @(negedge clk);
        req.awvalid = 1'b0;
        while (rsp.wready !== 1'b1 && edges < wait_limit) begin
            if (rsp.awready !== 1'b0) value_mismatch("awready", rsp.awready, 0);
            if (console_valid !== 1'b0) plain_error("console_valid pulsed before the data beat");
            @(negedge clk);
            edges++;
        end
        if (rsp.wready !== 1'b1) begin
            plain_error("wready never rose after a write address");
            return;
        end
        if (edges != `MEM_WRITE_LATENCY) value_mismatch("write latency", edges, `MEM_WRITE_LATENCY);
        req.wvalid = 1'b1;
        req.wdata  = data;
        req.wstrb  = 4'hF;
        @(negedge clk);
        req.wvalid = 1'b0;
        if (rsp.wready !== 1'b0) value_mismatch("wready", rsp.wready, 0);
        if (rsp.bvalid !== 1'b0) value_mismatch("bvalid", rsp.bvalid, 0);
        if (console_valid !== con) value_mismatch("console_valid", console_valid, con);
        if (con && console_byte !== data[7:0]) begin
            value_mismatch("console_byte", console_byte, data[7:0]);
        end
        // response one edge after the beat, then held through the stall
        for (int k = 0; k <= stall; k++) begin
            @(negedge clk);
            if (rsp.bvalid !== 1'b1) value_mismatch("bvalid", rsp.bvalid, 1);
            if (rsp.bresp !== 2'b00) value_mismatch("bresp", rsp.bresp, 0);
            if (rsp.awready !== 1'b0) value_mismatch("awready", rsp.awready, 0);
            if (console_valid !== 1'b0) plain_error("console_valid high for more than one cycle");
        end
        req.bready = 1'b1;
        @(negedge clk);
        req.bready = 1'b0;
        if (rsp.bvalid !== 1'b0) value_mismatch("bvalid", rsp.bvalid, 0);
        if (rsp.awready !== 1'b1) value_mismatch("awready", rsp.awready, 1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // retire groups and the reference tally
    task automatic retire_group(input logic [1:0] vld, input logic [31:0] w0,
                                input logic [6:0] m0, input logic [31:0] w1, input logic [6:0] m1);
        logic start_in;
        logic end_in;
        int   edges;
        start_in = (vld[0] && w0 == `START_MARKER) || (vld[1] && w1 == `START_MARKER);
        end_in   = (vld[0] && w0 == `END_MARKER) || (vld[1] && w1 == `END_MARKER);
        edges    = 0;
        // outside a window the counters must hold still
        if (!in_window) begin
            compare_counts();
            if (window_active !== 1'b0) value_mismatch("window_active", window_active, 0);
        end
        retire[0].valid     = vld[0];
        retire[0].instr.raw = w0;
        retire[1].valid     = vld[1];
        retire[1].instr.raw = w1;
        // every cycle strictly between the markers counts, idle or not
        if (end_in && in_window) exp_cnt[7] = cyc - start_cyc - 1;
        if (start_in) start_cyc = cyc;
        @(negedge clk);
        retire[0].valid = 1'b0;
        retire[1].valid = 1'b0;
        if (end_in) begin
            if (in_window) begin
                in_window = 1'b0;
                if (window_active !== 1'b1) value_mismatch("window_active", window_active, 1);
                while (stats_done !== 1'b1 && edges < wait_limit) begin
                    @(negedge clk);
                    edges++;
                end
                if (stats_done !== 1'b1) begin
                    plain_error("stats_done never pulsed after the end marker");
                end else begin
                    if (edges != 1) value_mismatch("stats_done delay", edges, 1);
                    if (window_active !== 1'b0) value_mismatch("window_active", window_active, 0);
                    compare_counts();
                    // done is a single-cycle pulse
                    @(negedge clk);
                    if (stats_done !== 1'b0) value_mismatch("stats_done", stats_done, 0);
                end
            end
        end else if (start_in) begin
            in_window = 1'b1;
            for (int k = 0; k < 8; k++) exp_cnt[k] = 0;
        end else if (in_window) begin
            for (int k = 0; k < 7; k++) begin
                if (vld[0] && m0[6-k]) exp_cnt[k]++;
                if (vld[1] && m1[6-k]) exp_cnt[k]++;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    function automatic step_t bus_step(input op_e op, input logic [31:0] addr,
                                       input logic [31:0] data, input logic con);
        step_t s;
        s     = '0;
        s.op  = op;
        s.a   = addr;
        s.d   = data;
        s.con = con;
        return s;
    endfunction

    function automatic step_t retire_step(input logic [1:0] vld, input logic [31:0] w0,
                                          input logic [6:0] m0, input logic [31:0] w1,
                                          input logic [6:0] m1);
        step_t s;
        s     = '0;
        s.op  = (vld == 2'b11 && w0 == '0) ? op_fill : op_retire;
        s.vld = vld;
        s.a   = w0;
        s.d   = w1;
        s.m0  = m0;
        s.m1  = m1;
        return s;
    endfunction

    task automatic load_table();
        steps[0]  = bus_step(op_read, 32'h0000_0100, 32'h0, 1'b0);
        steps[1]  = bus_step(op_write, 32'h0000_1000, 32'h48, 1'b1);
        steps[2]  = bus_step(op_write, 32'h0000_2000, 32'h55, 1'b0);
        // all-zero word pair means random filler
        steps[3]  = retire_step(2'b11, 32'h0, 7'h0, 32'h0, 7'h0);
        steps[4]  = retire_step(2'b11, `START_MARKER, 7'h0, 32'h003100B3, m_alu);
        steps[5]  = retire_step(2'b11, 32'h003100B3, m_alu, 32'h02000093, m_alu);
        steps[6]  = retire_step(2'b11, 32'h123452B7, m_alu, 32'h00000517, m_alu);
        steps[7]  = retire_step(2'b11, 32'h00208463, m_br, 32'h008000EF, m_br);
        steps[8]  = retire_step(2'b11, 32'h000080E7, m_br, 32'h023100B3, m_mul);
        steps[9]  = retire_step(2'b11, 32'h023140B3, m_div, 32'h023170B3, m_div);
        steps[10] = retire_step(2'b11, 32'h023130B3, m_mul, 32'h0000A083, m_ld);
        steps[11] = retire_step(2'b11, 32'h0010A023, m_st, 32'h0020A0AF, m_amo);
        steps[12] = retire_step(2'b11, 32'h00000073, m_misc, 32'h0FF0000F, m_misc);
        steps[13] = retire_step(2'b01, 32'h403100B3, m_alu, 32'h023100B3, m_mul);
        steps[14] = retire_step(2'b10, `START_MARKER, 7'h0, 32'h0020A0AF, m_amo);
        steps[15] = retire_step(2'b11, 32'h0, 7'h0, 32'h0, 7'h0);
        steps[16] = bus_step(op_read, 32'h0000_3000, 32'h0, 1'b0);
        steps[17] = bus_step(op_write, 32'h0000_1000, 32'h6B, 1'b1);
        steps[18] = retire_step(2'b11, 32'h0, 7'h0, 32'h0, 7'h0);
        steps[19] = retire_step(2'b11, 32'h003100B3, m_alu, `END_MARKER, 7'h0);
        steps[20] = retire_step(2'b11, 32'h0, 7'h0, 32'h0, 7'h0);
        steps[21] = retire_step(2'b11, 32'h023100B3, m_mul, 32'h023140B3, m_div);
        steps[22] = bus_step(op_write, 32'h0000_1004, 32'h21, 1'b0);
        steps[23] = retire_step(2'b11, `START_MARKER, 7'h0, `START_MARKER, 7'h0);
        steps[24] = retire_step(2'b11, 32'h0FF0000F, m_misc, 32'h00002007, 7'h0);
        steps[25] = retire_step(2'b11, 32'h0, 7'h0, 32'h0, 7'h0);
        // restart inside the window
        steps[26] = retire_step(2'b11, `START_MARKER, 7'h0, 32'h0000A083, m_ld);
        steps[27] = retire_step(2'b11, 32'h0020A0AF, m_amo, 32'h0020A0AF, m_amo);
        steps[28] = retire_step(2'b11, 32'h0, 7'h0, 32'h0, 7'h0);
        steps[29] = bus_step(op_write, 32'hABCD_1000, 32'h0A, 1'b1);
        steps[30] = retire_step(2'b00, `END_MARKER, 7'h0, `END_MARKER, 7'h0);
        steps[31] = retire_step(2'b11, 32'h00208463, m_br, 32'h0010A023, m_st);
        steps[32] = retire_step(2'b11, `END_MARKER, 7'h0, 32'h008000EF, m_br);
        steps[33] = retire_step(2'b11, 32'h0, 7'h0, 32'h0, 7'h0);
        steps[34] = bus_step(op_read, 32'h0000_0004, 32'h0, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        int p;
        int q;
        void'($urandom(seed));
        rst = 1'b1;
        req = '0;
        for (int i = 0; i < `RETIRE_PORTS; i++) retire[i] = '0;
        for (int k = 0; k < 8; k++) exp_cnt[k] = 0;
        load_table();
        repeat (rst_cycles) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (window_active !== 1'b0) value_mismatch("window_active", window_active, 0);
        if (stats_done !== 1'b0) value_mismatch("stats_done", stats_done, 0);
        if (console_valid !== 1'b0) value_mismatch("console_valid", console_valid, 0);
        if (rsp.rvalid !== 1'b0) value_mismatch("rvalid", rsp.rvalid, 0);
        if (rsp.bvalid !== 1'b0) value_mismatch("bvalid", rsp.bvalid, 0);
        for (int i = 0; i < num_steps; i++) begin
            case (steps[i].op)
                op_read:   read_word(steps[i].a);
                op_write:  write_word(steps[i].a, steps[i].d, steps[i].con);
                op_retire: retire_group(steps[i].vld, steps[i].a, steps[i].m0, steps[i].d,
                                        steps[i].m1);
                default: begin
                    p = $urandom_range(7, 0);
                    q = $urandom_range(7, 0);
                    retire_group(2'b11, fill_word[p], fill_mask[p], fill_word[q], fill_mask[q]);
                end
            endcase
        end
        repeat (2) @(negedge clk);
        $display("run complete: %0d steps, %0d errors", num_steps, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns with %0d errors", watchdog_ns, errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
